// ==== src.f ====
+incdir+include
src/core_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/commit_unit.sv
src/core_top.sv
verif/tb_clock.sv
verif/core_tb.sv

// ==== Makefile ====
SOURCES = include/core_cfg.svh src/core_pkg.sv src/inst_fetch.sv src/inst_decode.sv \
          src/reg_file.sv src/commit_unit.sv src/core_top.sv \
          verif/tb_clock.sv verif/core_tb.sv

.PHONY: all run check clean

all: check

obj_dir/Vcore_tb: $(SOURCES) src.f
	verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module core_tb

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb | tee sim.log

check: run
	@grep -q "All tests passed" sim.log || (echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== verif/core_tb.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_tb;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
        logic                    halt;
    } rec_t;

    localparam logic [`CORE_XLEN-1:0] EBREAK = 32'h0010_0073;

    logic                    clk;
    logic                    rst_n;
    logic                    inst_valid;
    logic                    inst_ready;
    logic [`CORE_XLEN-1:0]   inst;
    logic                    commit_valid;
    logic                    commit_ready;
    logic [`CORE_XLEN-1:0]   commit_pc;
    logic [`CORE_REG_AW-1:0] commit_rd;
    logic [`CORE_XLEN-1:0]   commit_data;
    logic                    commit_halt;
    logic                    halted;

    integer                seed;
    logic [`CORE_XLEN-1:0] prog [$];
    logic [`CORE_XLEN-1:0] ref_regs [0:31]; // shadow register file.
    rec_t                  exp_q [$];
    bit                    prog_built = 1'b0;

    tb_clock u_clock (.clk(clk));

    core_top UUT (.*);

    function automatic logic [31:0] imm_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13}; // addi.
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, op}; // lui or auipc.
    endfunction

    function automatic logic [31:0] reg_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33}; // add.
    endfunction

    // expected commit record from the rv32 semantics of each word.
    function automatic rec_t ref_model(input logic [31:0] w, input logic [31:0] pc);
        rec_t        r;
        logic [31:0] sum;
        logic [6:0]  op;
        logic        writes;
        op     = w[6:0];
        r.pc   = pc;
        r.rd   = '0;
        r.data = '0;
        r.halt = (w == EBREAK);
        writes = (op == 7'h17) || (op == 7'h37) || (op == 7'h13 && w[14:12] == 3'b000)
                 || (op == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h00);
        case (op)
            7'h13:   sum = {{20{w[31]}}, w[31:20]} + ref_regs[w[19:15]];
            7'h17:   sum = pc + {w[31:12], 12'h000};
            7'h37:   sum = {w[31:12], 12'h000};
            default: sum = ref_regs[w[19:15]] + ref_regs[w[24:20]];
        endcase
        if (writes) begin
            r.rd   = w[11:7];
            r.data = sum;
            if (w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = sum; // x0 keeps reading zero.
            end
        end
        return r;
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        prog.push_back(imm_word(5'd1, 5'd0, 12'd5));
        prog.push_back(upper_word(7'h37, 5'd2, 20'h12345));
        prog.push_back(imm_word(5'd2, 5'd2, 12'h678));
        prog.push_back(upper_word(7'h17, 5'd3, 20'h00001));
        prog.push_back(reg_word(5'd4, 5'd1, 5'd2)); // reads the two previous results.
        prog.push_back(reg_word(5'd5, 5'd4, 5'd3));
        prog.push_back(imm_word(5'd0, 5'd1, 12'hfff));
        prog.push_back(reg_word(5'd6, 5'd0, 5'd1));
        prog.push_back(32'h0000_2003); // lw is not supported.
        repeat (40) begin
            r   = $random(seed);
            rd  = {2'b00, r[9:7]};
            rs1 = {2'b00, r[12:10]};
            rs2 = {2'b00, r[15:13]};
            case (r[6:4])
                3'd0, 3'd1: prog.push_back(imm_word(rd, rs1, r[31:20]));
                3'd2:       prog.push_back(upper_word(7'h37, rd, r[31:12]));
                3'd3:       prog.push_back(upper_word(7'h17, rd, r[31:12]));
                3'd4, 3'd5: prog.push_back(reg_word(rd, rs1, rs2));
                default:    prog.push_back({r[31:7], 7'h0f}); // fence is unknown here.
            endcase
        end
        prog.push_back(EBREAK);
        pc = `CORE_RESET_PC;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        foreach (prog[i]) begin
            exp_q.push_back(ref_model(prog[i], pc));
            pc = pc + 32'd4;
        end
        prog_built = 1'b1;
    endtask

    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`CORE_XLEN-1:0] expected,
                              input logic [`CORE_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input logic [`CORE_REG_AW-1:0] expected,
                             input logic [`CORE_REG_AW-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    initial begin
        int idx;
        int tail;
        seed         = 31;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        commit_ready = 1'b0;
        idx          = 0;
        tail         = 0;
        build_program();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #2;
        check_bit("inst_ready", 1'b0, inst_ready); // fetch waits one cycle after reset.
        check_bit("commit_valid", 1'b0, commit_valid);
        check_bit("halted", 1'b0, halted);
        while (tail < 20) begin
            @(posedge clk);
            #1;
            commit_ready = ($random(seed) & 3) != 0;
            inst_valid   = (idx >= prog.size()) || (($random(seed) & 3) != 0);
            inst         = (idx < prog.size()) ? prog[idx] : imm_word(5'd1, 5'd1, 12'd1);
            #2;
            if (inst_valid && inst_ready && idx < prog.size()) begin
                idx++;
            end
            if (exp_q.size() == 0) begin
                check_bit("inst_ready", 1'b0, inst_ready); // halted after ebreak.
                tail++;
            end
        end
        if (halted !== 1'b1) begin
            $display("core did not halt after the ebreak record");
            end_with_failure();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    // scoreboard samples mid-cycle before the handshake edge.
    initial begin
        rec_t want;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && commit_valid && commit_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a commit record arrived when none was expected");
                    end_with_failure();
                end else begin
                    want = exp_q.pop_front();
                    check_word("commit_pc", want.pc, commit_pc);
                    check_reg("commit_rd", want.rd, commit_rd);
                    check_word("commit_data", want.data, commit_data);
                    check_bit("commit_halt", want.halt, commit_halt);
                end
            end
        end
    end

    initial begin
        wait (prog_built);
        repeat (20 * prog.size() + 100) @(posedge clk);
        $display("timeout, the program did not finish in time");
        end_with_failure();
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 2; // 4 ns period.

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk = ~clk;
        end
    end

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_valid,
    output logic                    inst_ready,
    input  logic [`CORE_XLEN-1:0]   inst,
    output logic                    commit_valid,
    input  logic                    commit_ready,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic [`CORE_XLEN-1:0]   commit_data,
    output logic                    commit_halt,
    output logic                    halted
);

    import core_pkg::*;

    logic                    slot_valid;
    logic                    slot_take;
    logic [`CORE_XLEN-1:0]   slot_inst;
    logic [`CORE_XLEN-1:0]   slot_pc;
    logic [`CORE_REG_AW-1:0] raddr1;
    logic [`CORE_REG_AW-1:0] raddr2;
    logic [`CORE_XLEN-1:0]   rdata1;
    logic [`CORE_XLEN-1:0]   rdata2;
    logic [`CORE_XLEN-1:0]   src1;
    logic [`CORE_XLEN-1:0]   src2;
    logic [`CORE_REG_AW-1:0] des;
    exu_cmd_e                command;
    logic                    wen;
    logic [`CORE_REG_AW-1:0] waddr;
    logic [`CORE_XLEN-1:0]   wdata;

    inst_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .halted     (halted),
        .slot_take  (slot_take),
        .slot_valid (slot_valid),
        .slot_inst  (slot_inst),
        .slot_pc    (slot_pc)
    );

    inst_decode u_decode (
        .inst    (slot_inst),
        .pc      (slot_pc),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .src1    (src1),
        .src2    (src2),
        .des     (des),
        .command (command)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    commit_unit u_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_valid   (slot_valid),
        .slot_pc      (slot_pc),
        .slot_take    (slot_take),
        .src1         (src1),
        .src2         (src2),
        .des          (des),
        .command      (command),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .halted       (halted),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_halt  (commit_halt)
    );

endmodule

// ==== src/commit_unit.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module commit_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    slot_valid,
    input  logic [`CORE_XLEN-1:0]   slot_pc,
    output logic                    slot_take,
    input  logic [`CORE_XLEN-1:0]   src1,
    input  logic [`CORE_XLEN-1:0]   src2,
    input  logic [`CORE_REG_AW-1:0] des,
    input  core_pkg::exu_cmd_e      command,
    output logic                    wen,
    output logic [`CORE_REG_AW-1:0] waddr,
    output logic [`CORE_XLEN-1:0]   wdata,
    output logic                    halted,
    output logic                    commit_valid,
    input  logic                    commit_ready,
    output logic [`CORE_XLEN-1:0]   commit_pc,
    output logic [`CORE_REG_AW-1:0] commit_rd,
    output logic [`CORE_XLEN-1:0]   commit_data,
    output logic                    commit_halt
);

    import core_pkg::*;

    logic                    out_free;
    logic                    is_add;
    logic                    is_halt;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   result;

    assign out_free  = !commit_valid || commit_ready; // empty or draining.
    assign slot_take = slot_valid && out_free && !halted;

    assign is_add  = (command == CMD_ADD);
    assign is_halt = (command == CMD_HALT);

    // nop and halt retire with rd 0 and data 0.
    assign result = is_add ? src1 + src2 : '0;
    assign rd     = is_add ? des : '0;

    assign wen   = slot_take && is_add;
    assign waddr = rd;
    assign wdata = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            if (slot_take) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
            if (slot_take && is_halt) begin
                halted <= 1'b1; // held until reset.
            end
        end
    end

    // record only loads when the output register is free.
    always_ff @(posedge clk) begin
        if (slot_take) begin
            commit_pc   <= slot_pc;
            commit_rd   <= rd;
            commit_data <= result;
            commit_halt <= is_halt;
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CORE_REG_AW-1:0] raddr1,
    input  logic [`CORE_REG_AW-1:0] raddr2,
    output logic [`CORE_XLEN-1:0]   rdata1,
    output logic [`CORE_XLEN-1:0]   rdata2,
    input  logic                    wen,
    input  logic [`CORE_REG_AW-1:0] waddr,
    input  logic [`CORE_XLEN-1:0]   wdata
);

    localparam int DEPTH = 2 ** `CORE_REG_AW;

    logic [`CORE_XLEN-1:0] regs [1:DEPTH-1]; // x0 has no storage.

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== src/inst_decode.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module inst_decode (
    input  logic [`CORE_XLEN-1:0]   inst,
    input  logic [`CORE_XLEN-1:0]   pc,
    input  logic [`CORE_XLEN-1:0]   rdata1,
    input  logic [`CORE_XLEN-1:0]   rdata2,
    output logic [`CORE_REG_AW-1:0] raddr1,
    output logic [`CORE_REG_AW-1:0] raddr2,
    output logic [`CORE_XLEN-1:0]   src1,
    output logic [`CORE_XLEN-1:0]   src2,
    output logic [`CORE_REG_AW-1:0] des,
    output core_pkg::exu_cmd_e      command
);

    import core_pkg::*;

    typedef enum logic [6:0] {
        OP_IMM   = 7'b00100_11,
        OP_AUIPC = 7'b00101_11,
        OP_LUI   = 7'b01101_11,
        OP_REG   = 7'b01100_11,
        OP_SYS   = 7'b11100_11
    } opcode_e;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  reg1_ren;
    logic                  reg2_ren;
    logic                  wreg_wen;
    imm_type_e             imm_type;
    logic [`CORE_XLEN-1:0] imm;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // unused read ports stay on x0.
    assign raddr1 = reg1_ren ? inst[19:15] : '0;
    assign raddr2 = reg2_ren ? inst[24:20] : '0;
    assign des    = wreg_wen ? inst[11:7] : '0;

    always_comb begin
        case (imm_type)
            IMM_I:   imm = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
            IMM_U:   imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        imm_type = IMM_N;
        command  = CMD_NOP;
        src1     = '0;
        src2     = '0;
        reg1_ren = 1'b0;
        reg2_ren = 1'b0;
        wreg_wen = 1'b0;
        case (opcode)
            OP_IMM: begin
                if (funct3 == 3'b000) begin // addi.
                    imm_type = IMM_I;
                    command  = CMD_ADD;
                    src1     = imm;
                    src2     = rdata1;
                    reg1_ren = 1'b1;
                    wreg_wen = 1'b1;
                end
            end
            OP_AUIPC: begin
                imm_type = IMM_U;
                command  = CMD_ADD;
                src1     = pc;
                src2     = imm;
                wreg_wen = 1'b1;
            end
            OP_LUI: begin
                imm_type = IMM_U;
                command  = CMD_ADD;
                src2     = imm; // src1 stays zero.
                wreg_wen = 1'b1;
            end
            OP_REG: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin // add.
                    command  = CMD_ADD;
                    src1     = rdata1;
                    src2     = rdata2;
                    reg1_ren = 1'b1;
                    reg2_ren = 1'b1;
                    wreg_wen = 1'b1;
                end
            end
            OP_SYS: begin
                // only the exact ebreak word halts.
                if (inst[31:7] == 25'h0002000) begin
                    command = CMD_HALT;
                end
            end
            default: begin
                command = CMD_NOP;
            end
        endcase
    end

endmodule

// ==== src/inst_fetch.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module inst_fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  logic [`CORE_XLEN-1:0] inst,
    input  logic                  halted,
    input  logic                  slot_take,
    output logic                  slot_valid,
    output logic [`CORE_XLEN-1:0] slot_inst,
    output logic [`CORE_XLEN-1:0] slot_pc
);

    localparam logic [`CORE_XLEN-1:0] PC_STEP = 4;

    logic [`CORE_XLEN-1:0] pc;
    logic                  fetch_en; // stays low for one cycle after reset.
    logic                  accept;

    // the slot frees up in the same cycle that commit takes it.
    assign inst_ready = fetch_en && !halted && (!slot_valid || slot_take);
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= `CORE_RESET_PC;
            fetch_en   <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (accept) begin
                pc         <= pc + PC_STEP;
                slot_valid <= 1'b1;
            end else if (slot_take) begin
                slot_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_inst <= inst;
            slot_pc   <= pc; // pc of the word just accepted.
        end
    end

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

    // command handed from decode to the commit stage.
    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,
        CMD_ADD  = 2'd1,
        CMD_HALT = 2'd2
    } exu_cmd_e;

    // immediate format selected by the decoder.
    typedef enum logic [1:0] {
        IMM_N = 2'd0,
        IMM_I = 2'd1,
        IMM_U = 2'd2
    } imm_type_e;

endpackage

// ==== include/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and pc width.
`define CORE_XLEN 32

// register file address width.
`define CORE_REG_AW 5

// pc of the first fetched instruction.
`define CORE_RESET_PC 32'h8000_0000

`endif
